/* uart_tx_top.f */
uart_pkg.sv
uart_bus_port.sv
uart_baud_timer.sv
uart_tx_serializer.sv
uart_tx_top.sv
tb_uart_frame_monitor.sv
tb_uart_tx_top.sv

/* Bender.yml */
package:
  name: uart_tx_top

sources:
  - files:
      - uart_pkg.sv
      - uart_bus_port.sv
      - uart_baud_timer.sv
      - uart_tx_serializer.sv
      - uart_tx_top.sv
  - target: test
    files:
      - tb_uart_frame_monitor.sv
      - tb_uart_tx_top.sv

/* tb_uart_tx_top.sv */
module tb_uart_tx_top;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int reset_cycles = 16;
	localparam int drive_delay  = 5;
	localparam int frame_cycles = 10 * uart_pkg::bit_cycles;
	// longest single wait, a full frame in flight plus one queued behind it
	localparam int wait_limit   = 4 * frame_cycles;
	localparam int run_limit    = 10000;

	logic       clk;
	logic       reset_n;
	logic [7:0] bus_address;
	logic       bus_write;
	logic       bus_valid;
	logic [7:0] bus_wdata;
	logic       bus_ready;
	logic       uart_tx;

	logic        frame_mismatch;
	int          frames_started;
	int          frames_done;
	int          accepted_count;
	logic [15:0] lfsr;

	always #50 clk = ~clk;

	uart_tx_top DUT (
		.clk         (clk),
		.reset_n     (reset_n),
		.bus_address (bus_address),
		.bus_write   (bus_write),
		.bus_valid   (bus_valid),
		.bus_wdata   (bus_wdata),
		.bus_ready   (bus_ready),
		.uart_tx     (uart_tx)
	);

	// rebuilds frames from the line and matches them to accepted bytes
	tb_uart_frame_monitor frame_mon (
		.clk            (clk),
		.reset_n        (reset_n),
		.uart_tx        (uart_tx),
		.mismatch       (frame_mismatch),
		.frames_started (frames_started),
		.frames_done    (frames_done)
	);

	// ----------------------------------------
	// failure handling
	// ----------------------------------------

	task automatic abort_run();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic show_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("Fail %s expected 0x%0h got 0x%0h", name, expected, actual);
		abort_run();
	endtask

	task automatic wait_expired(input string what);
		$display("Timed out waiting for %s", what);
		abort_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else show_mismatch(name, expected, actual);
	endtask

	always @(posedge frame_mismatch) begin
		abort_run();
	end

	// ready may only show up for a write aimed at the data register
	a_ready_only_data_writes: assert property (
		@(posedge clk) disable iff (!reset_n)
		bus_ready |-> (bus_address == uart_pkg::tx_data_addr && bus_write)
	) else show_mismatch("bus_ready", 0, 1);

	// with every accepted byte already framed the line has to rest high
	a_line_idle: assert property (
		@(posedge clk) disable iff (!reset_n)
		(accepted_count == frames_done) |-> uart_tx
	) else show_mismatch("uart_tx", 1, 0);

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------

	// x^16 + x^14 + x^13 + x^11 + 1, one step gives one new bit
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], feedback};
	endfunction

	task automatic random_byte(output logic [7:0] value);
		int i;
		value = 8'h00;
		for (i = 0; i < 8; i++) begin
			lfsr  = lfsr_step(lfsr);
			value = {value[6:0], lfsr[0]};
		end
	endtask

	task automatic next_drive();
		@(posedge clk);
		#drive_delay;
	endtask

	task automatic apply_reset();
		reset_n = 1'b0;
		repeat (reset_cycles - 1) @(posedge clk);
		@(negedge clk);
		check_value("uart_tx", 1, uart_tx);
		check_value("bus_ready", 0, bus_ready);
		check_value("send_req", 0, DUT.send_req);
		check_value("send_busy", 0, DUT.send_busy);
		check_value("bit_tick", 0, DUT.bit_tick);
		next_drive();
		reset_n = 1'b1;
	endtask

	// holds the write until ready is seen, the next rising edge takes it
	task automatic write_byte(input logic [7:0] data);
		int waited;
		waited      = 0;
		bus_address = uart_pkg::tx_data_addr;
		bus_write   = 1'b1;
		bus_valid   = 1'b1;
		bus_wdata   = data;
		@(negedge clk);
		while (!bus_ready) begin
			if (waited >= wait_limit) begin
				wait_expired("bus_ready on a write to the data address");
			end else begin
				waited++;
				@(negedge clk);
			end
		end
		@(posedge clk);
		frame_mon.expect_byte(data);
		accepted_count++;
		#drive_delay;
		bus_valid = 1'b0;
		bus_write = 1'b0;
	endtask

	task automatic wait_frames_done(input int target);
		int waited;
		waited = 0;
		while (frames_done < target) begin
			if (waited >= wait_limit) begin
				wait_expired("the monitor to finish a frame");
			end else begin
				waited++;
				@(negedge clk);
			end
		end
		next_drive();
	endtask

	// an access the bus must never take, held for three bit times
	task automatic hold_rejected(input logic [7:0] address, input logic write,
			input logic [7:0] data);
		int i;
		bus_address = address;
		bus_write   = write;
		bus_valid   = 1'b1;
		bus_wdata   = data;
		for (i = 0; i < 3 * uart_pkg::bit_cycles; i++) begin
			@(negedge clk);
			check_value("bus_ready", 0, bus_ready);
		end
		next_drive();
		bus_valid = 1'b0;
		bus_write = 1'b0;
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < run_limit) begin
			@(posedge clk);
			cycles++;
		end
		wait_expired("the test sequence to finish");
	end

	initial begin : sequence_main
		int         i;
		int         base;
		int         waited;
		int         starts_before;
		logic [7:0] data;
		logic [7:0] addr;

		clk            = 1'b0;
		reset_n        = 1'b0;
		bus_address    = 8'h00;
		bus_write      = 1'b0;
		bus_valid      = 1'b0;
		bus_wdata      = 8'h00;
		accepted_count = 0;
		lfsr           = 16'd8341;
		apply_reset();

		// idle line, and ready for a write to the data address
		bus_address = uart_pkg::tx_data_addr;
		bus_write   = 1'b1;
		for (i = 0; i < uart_pkg::bit_cycles; i++) begin
			@(negedge clk);
			check_value("uart_tx", 1, uart_tx);
			check_value("bus_ready", 1, bus_ready);
		end
		next_drive();
		bus_write = 1'b0;

		// twenty bytes back to back, framing and order checked by the monitor
		for (i = 0; i < 20; i++) begin
			random_byte(data);
			write_byte(data);
		end
		wait_frames_done(accepted_count);

		// one byte on the line and one queued behind it
		base = frames_done;
		random_byte(data);
		write_byte(data);
		random_byte(data);
		write_byte(data);
		// the second byte is taken while the first frame is still shifting
		check_value("frames_done", base, frames_done);
		bus_address = uart_pkg::tx_data_addr;
		bus_write   = 1'b1;
		waited      = 0;
		@(negedge clk);
		while (frames_done < base + 1) begin
			if (waited >= wait_limit) begin
				wait_expired("the first of two queued frames");
			end else begin
				check_value("bus_ready", 0, bus_ready);
				waited++;
				@(negedge clk);
			end
		end
		wait_frames_done(base + 2);
		for (i = 0; i < uart_pkg::bit_cycles; i++) begin
			@(negedge clk);
			check_value("uart_tx", 1, uart_tx);
		end
		check_value("bus_ready", 1, bus_ready);
		next_drive();
		bus_write = 1'b0;

		// other addresses and reads are never accepted and start no frame
		starts_before = frames_started;
		for (i = 0; i < 4; i++) begin
			random_byte(addr);
			if (addr == uart_pkg::tx_data_addr) begin
				addr = addr ^ 8'h01;
			end
			random_byte(data);
			hold_rejected(addr, 1'b1, data);
		end
		random_byte(data);
		hold_rejected(uart_pkg::tx_data_addr, 1'b0, data);
		for (i = 0; i < 12 * uart_pkg::bit_cycles; i++) begin
			@(negedge clk);
			check_value("uart_tx", 1, uart_tx);
		end
		check_value("frames_started", starts_before, frames_started);

		check_value("monitor byte queue size", 0, frame_mon.bytes_waiting());
		check_value("frames_done", accepted_count, frames_done);
		$display("No errors");
		$finish;
	end

endmodule

/* tb_uart_frame_monitor.sv */
module tb_uart_frame_monitor (
	input  logic clk,
	input  logic reset_n,
	input  logic uart_tx,
	output logic mismatch,
	output int   frames_started,
	output int   frames_done
);

	timeunit 1ns;
	timeprecision 100ps;

	// bytes the host has had accepted, oldest first
	logic [7:0] expected_q[$];

	// receiver state, counted in falling clock edges from the start edge
	logic       in_frame;
	logic       line_prev;
	int         count;
	int         bit_idx;
	logic [7:0] rebuilt;
	logic [7:0] expected;

	initial begin
		mismatch       = 1'b0;
		frames_started = 0;
		frames_done    = 0;
		in_frame       = 1'b0;
		line_prev      = 1'b1;
		count          = 0;
		bit_idx        = 0;
		rebuilt        = 8'h00;
		expected       = 8'h00;
	end

	// called by the testbench top for every byte the bus accepted
	task automatic expect_byte(input logic [7:0] value);
		expected_q.push_back(value);
	endtask

	function automatic int bytes_waiting();
		return expected_q.size();
	endfunction

	task automatic raise_mismatch(input string name, input logic [7:0] exp_val,
			input logic [7:0] act_val);
		$display("Fail %s expected 0x%0h got 0x%0h", name, exp_val, act_val);
		mismatch = 1'b1;
	endtask

	// ----------------------------------------
	// line sampler
	// ----------------------------------------

	// the line changes on rising edges, so falling edges see it settled.
	// bit k of a frame covers edges k*bit_cycles up to k*bit_cycles + bit_cycles - 1
	// after the start edge, and it is sampled in the middle of that span
	always @(negedge clk) begin
		if (!reset_n) begin
			in_frame = 1'b0;
		end else if (!in_frame) begin
			if (line_prev && !uart_tx) begin
				assert (expected_q.size() != 0) else begin
					$display("Start bit seen on uart_tx with no accepted byte to match it");
					mismatch = 1'b1;
				end
				in_frame = 1'b1;
				count    = 0;
				frames_started <= frames_started + 1;
			end
		end else begin
			count = count + 1;
			if (count % uart_pkg::bit_cycles == uart_pkg::bit_cycles / 2) begin
				bit_idx = count / uart_pkg::bit_cycles;
				if (bit_idx == 0) begin
					assert (uart_tx == 1'b0) else
						raise_mismatch("uart_tx start bit", 8'h00, {7'h00, uart_tx});
				end else if (bit_idx <= 8) begin
					// data comes lsb first
					rebuilt[bit_idx - 1] = uart_tx;
				end else begin
					assert (uart_tx == 1'b1) else
						raise_mismatch("uart_tx stop bit", 8'h01, {7'h00, uart_tx});
					if (expected_q.size() != 0) begin
						expected = expected_q.pop_front();
					end
					assert (rebuilt == expected) else
						raise_mismatch("uart_tx data", expected, rebuilt);
					frames_done <= frames_done + 1;
					in_frame = 1'b0;
				end
			end
		end
		line_prev = uart_tx;
	end

endmodule

/* uart_tx_top.sv */
module uart_tx_top (
	input  logic       clk,
	input  logic       reset_n,

	// register bus from the host
	input  logic [7:0] bus_address,
	input  logic       bus_write,
	input  logic       bus_valid,
	input  logic [7:0] bus_wdata,
	output logic       bus_ready,

	// serial output
	output logic       uart_tx
);

	// ----------------------------------------
	// internal wires
	// ----------------------------------------

	// byte and request from the bus port, busy back from the serializer
	logic [7:0] send_data;
	logic       send_req;
	logic       send_busy;

	// bit rate pulse shared by the whole frame
	logic       bit_tick;

	// bus decode and the one-byte holding register
	uart_bus_port u_bus_port (
		.clk         (clk),
		.reset_n     (reset_n),
		.bus_address (bus_address),
		.bus_write   (bus_write),
		.bus_valid   (bus_valid),
		.bus_wdata   (bus_wdata),
		.bus_ready   (bus_ready),
		.send_data   (send_data),
		.send_req    (send_req),
		.send_busy   (send_busy)
	);

	// fixed divider, runs freely from reset on
	uart_baud_timer u_baud_timer (
		.clk      (clk),
		.reset_n  (reset_n),
		.bit_tick (bit_tick)
	);

	// frame builder that drives the line
	uart_tx_serializer u_serializer (
		.clk       (clk),
		.reset_n   (reset_n),
		.bit_tick  (bit_tick),
		.send_data (send_data),
		.send_req  (send_req),
		.send_busy (send_busy),
		.uart_tx   (uart_tx)
	);

endmodule

/* uart_tx_serializer.sv */
module uart_tx_serializer (
	input  logic       clk,
	input  logic       reset_n,

	// bit boundary pulse from the baud timer
	input  logic       bit_tick,

	// byte request from the bus port
	input  logic [7:0] send_data,
	input  logic       send_req,
	output logic       send_busy,

	// serial line, idles high
	output logic       uart_tx
);

	// frame state
	uart_pkg::tx_state_t state;

	// data bits still to go out, lsb first
	logic [7:0] shift;

	// index of the data bit currently on the line
	logic [2:0] bit_cnt;

	// ----------------------------------------
	// payload shift register
	// ----------------------------------------

	// loaded when a byte is taken and shifted right each time a data bit
	// goes onto the line, so bit 0 is always the next one to send
	always_ff @(posedge clk) begin
		if (state == uart_pkg::tx_idle && !send_busy && send_req) begin
			shift <= send_data;
		end else if (bit_tick && (state == uart_pkg::tx_start ||
				state == uart_pkg::tx_data)) begin
			shift <= {1'b0, shift[7:1]};
		end
	end

	// ----------------------------------------
	// frame state machine
	// ----------------------------------------

	// every move between states waits for bit_tick, so each bit on the
	// line is held for exactly one tick period.
	// idle with busy high means a byte is latched and we wait for the tick
	// that starts the frame, which lines the start bit up with the timer
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state     <= uart_pkg::tx_idle;
			send_busy <= 1'b0;
			uart_tx   <= 1'b1;
			bit_cnt   <= 3'd0;
		end else begin
			case (state)
				uart_pkg::tx_idle: begin
					if (!send_busy) begin
						// take the byte, busy shows the bus port it was seen
						if (send_req) begin
							send_busy <= 1'b1;
						end
					end else if (bit_tick) begin
						// start bit
						state   <= uart_pkg::tx_start;
						uart_tx <= 1'b0;
					end
				end

				uart_pkg::tx_start: begin
					if (bit_tick) begin
						// first data bit is the lsb of the byte
						state   <= uart_pkg::tx_data;
						uart_tx <= shift[0];
						bit_cnt <= 3'd0;
					end
				end

				uart_pkg::tx_data: begin
					if (bit_tick) begin
						if (bit_cnt == 3'd7) begin
							// all eight data bits done, drive the stop bit
							state   <= uart_pkg::tx_stop;
							uart_tx <= 1'b1;
						end else begin
							uart_tx <= shift[0];
							bit_cnt <= bit_cnt + 3'd1;
						end
					end
				end

				uart_pkg::tx_stop: begin
					// line is already high, only the state and busy change here
					if (bit_tick) begin
						state     <= uart_pkg::tx_idle;
						send_busy <= 1'b0;
					end
				end

				default: begin
					state <= uart_pkg::tx_idle;
				end
			endcase
		end
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------

	// the line must rest at mark level whenever no frame is on it
	a_idle_line_high: assert property (
		@(posedge clk) disable iff (!reset_n)
		(state == uart_pkg::tx_idle) |-> uart_tx
	);

	// busy low outside idle would let the bus port push a new request into
	// the middle of a frame
	a_busy_outside_idle: assert property (
		@(posedge clk) disable iff (!reset_n)
		!send_busy |-> (state == uart_pkg::tx_idle)
	);

endmodule

/* uart_baud_timer.sv */
module uart_baud_timer (
	input  logic clk,
	input  logic reset_n,

	// one-cycle pulse that marks every bit boundary on the line
	output logic bit_tick
);

	// reload value, one less than the bit period since zero counts as a cycle
	localparam logic [uart_pkg::baud_cnt_w-1:0] reload =
		uart_pkg::baud_cnt_w'(uart_pkg::bit_cycles - 1);

	// cycles left until the next tick
	logic [uart_pkg::baud_cnt_w-1:0] count;

	// ----------------------------------------
	// free-running divider
	// ----------------------------------------

	// the counter runs from reset on and never stops, the serializer just
	// ignores ticks while it has nothing to send.
	// the tick is registered so it comes out clean for a whole cycle
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			count    <= reload;
			bit_tick <= 1'b0;
		end else if (count == '0) begin
			count    <= reload;
			bit_tick <= 1'b1;
		end else begin
			count    <= count - 1'b1;
			bit_tick <= 1'b0;
		end
	end

	// back to back ticks would make every bit one cycle long and break the
	// frame timing downstream
	a_tick_single_cycle: assert property (
		@(posedge clk) disable iff (!reset_n)
		bit_tick |=> !bit_tick
	);

endmodule

/* uart_bus_port.sv */
module uart_bus_port (
	input  logic       clk,
	input  logic       reset_n,

	// host side of the byte-wide register bus
	input  logic [7:0] bus_address,
	input  logic       bus_write,
	input  logic       bus_valid,
	input  logic [7:0] bus_wdata,
	output logic       bus_ready,

	// request towards the serializer
	output logic [7:0] send_data,
	output logic       send_req,
	input  logic       send_busy
);

	// address hit on the transmit data register
	logic addr_hit;

	// a write is taken in this cycle
	logic accept;

	// the holding register has a byte the serializer has not yet taken
	logic pending;

	// ----------------------------------------
	// decode and ready
	// ----------------------------------------

	assign addr_hit = (bus_address == uart_pkg::tx_data_addr);

	// only writes to the data address can ever complete, reads and other
	// addresses just see ready stay low and the host keeps waiting.
	// the holding register frees up as soon as the serializer has taken the
	// byte, so a second byte can wait here while the first one is shifting
	assign bus_ready = addr_hit & bus_write & ~pending;

	assign accept = bus_valid & bus_ready;

	// ----------------------------------------
	// holding register
	// ----------------------------------------

	// the byte itself is plain payload and only changes on an accepted write
	always_ff @(posedge clk) begin
		if (accept) begin
			send_data <= bus_wdata;
		end
	end

	// pending is set by the write and cleared when the serializer shows busy
	// while our request is still up, which is its acknowledge of the byte
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pending <= 1'b0;
		end else if (accept) begin
			pending <= 1'b1;
		end else if (send_req && send_busy) begin
			pending <= 1'b0;
		end
	end

	// ----------------------------------------
	// request to the serializer
	// ----------------------------------------

	// the request is only raised while the serializer is idle, so busy seen
	// with the request up can only mean this byte was latched.
	// a byte written during a frame stays queued until busy drops
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			send_req <= 1'b0;
		end else if (send_req) begin
			if (send_busy) begin
				send_req <= 1'b0;
			end
		end else if ((pending || accept) && !send_busy) begin
			send_req <= 1'b1;
		end
	end

	// a request rising into a busy serializer would be acknowledged by the
	// previous frame and the queued byte would be lost
	a_req_rise_not_busy: assert property (
		@(posedge clk) disable iff (!reset_n)
		$rose(send_req) |-> !send_busy
	);

endmodule

/* uart_pkg.sv */
package uart_pkg;

	// ----------------------------------------
	// clock and baud rate
	// ----------------------------------------

	// system clock frequency in Hz
	localparam int unsigned clk_freq = 10_000_000;

	// serial line rate in bits per second
	localparam int unsigned uart_freq = 1_000_000;

	// number of clock cycles that make up one bit on the line.
	// every bit period in the design is derived from this value, so a new
	// baud rate only needs the two numbers above to change
	localparam int unsigned bit_cycles = clk_freq / uart_freq;

	// width of the baud down-counter, large enough to hold bit_cycles - 1
	localparam int unsigned baud_cnt_w = (bit_cycles > 1) ? $clog2(bit_cycles) : 1;

	// ----------------------------------------
	// register map
	// ----------------------------------------

	// the only register on the bus, a write-only transmit data byte
	localparam logic [7:0] tx_data_addr = 8'h10;

	// ----------------------------------------
	// serializer states
	// ----------------------------------------

	// tx_idle also covers the wait for the first tick after a byte is taken.
	// the line only goes low once the machine has moved to tx_start
	typedef enum logic [1:0] {
		tx_idle  = 2'd0,
		tx_start = 2'd1,
		tx_data  = 2'd2,
		tx_stop  = 2'd3
	} tx_state_t;

endpackage
